// File: Bender.yml
package:
  name: exu

sources:
  # Package first, then the stages, then the top level
  - hw/exu_pkg.sv
  - hw/exu_decode.sv
  - hw/exu_regfile.sv
  - hw/exu_disp.sv
  - hw/exu_alu.sv
  - hw/exu_top.sv
  - target: simulation
    files:
      - sim/tb_exu.sv

// File: hw/exu_alu.sv
// RV32I execution stage, ALU
// Computes the ten integer operations, offers the result for forwarding
// and holds it in the write-back register

`timescale 1ns/1ps
`default_nettype none

module exu_alu import exu_pkg::*; (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_ex_valid,
  input  logic [ALU_OP_W-1:0] i_ex_aluop,
  input  logic [XLEN-1:0]     i_ex_op1,
  input  logic [XLEN-1:0]     i_ex_op2,
  input  logic                i_ex_rdwen,
  input  logic [RFIDX_W-1:0]  i_ex_rdidx,
  input  logic                i_ex_ilegl,
  output logic                o_ex_fwd_ena,
  output logic [RFIDX_W-1:0]  o_ex_fwd_rdidx,
  output logic [XLEN-1:0]     o_ex_fwd_wdat,
  output logic                o_wbck_ena,
  output logic [RFIDX_W-1:0]  o_wbck_rdidx,
  output logic [XLEN-1:0]     o_wbck_wdat,
  output logic                o_ilegl
);

  logic                      sub_op;
  logic [XLEN:0]             add_res;  // Carry out on top
  logic                      ltu;
  logic                      lts;
  logic [$clog2(XLEN)-1:0]   shamt;
  logic [XLEN-1:0]           alu_res;

  ////////////////////////////////////////////////////////////
  // Shared adder
  // Everything but ADD runs op1 - op2, which also feeds the compares
  assign sub_op  = (i_ex_aluop != ALU_ADD);
  assign add_res = {1'b0, i_ex_op1} + {1'b0, (sub_op ? ~i_ex_op2 : i_ex_op2)} +
                   {{XLEN{1'b0}}, sub_op};

  assign ltu   = ~add_res[XLEN];  // Borrow
  assign lts   = (i_ex_op1[XLEN-1] ^ i_ex_op2[XLEN-1]) ? i_ex_op1[XLEN-1] : ltu;
  assign shamt = i_ex_op2[$clog2(XLEN)-1:0];

  always_comb begin
    case (i_ex_aluop)
      ALU_ADD,
      ALU_SUB:  alu_res = add_res[XLEN-1:0];
      ALU_SLL:  alu_res = i_ex_op1 << shamt;
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, lts};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, ltu};
      ALU_XOR:  alu_res = i_ex_op1 ^ i_ex_op2;
      ALU_SRL:  alu_res = i_ex_op1 >> shamt;
      ALU_SRA:  alu_res = $signed(i_ex_op1) >>> shamt;
      ALU_OR:   alu_res = i_ex_op1 | i_ex_op2;
      ALU_AND:  alu_res = i_ex_op1 & i_ex_op2;
      default:  alu_res = '0;
    endcase
  end

  // Newest forwarding source for dispatch
  assign o_ex_fwd_ena   = i_ex_valid & i_ex_rdwen;
  assign o_ex_fwd_rdidx = i_ex_rdidx;
  assign o_ex_fwd_wdat  = alu_res;

  ////////////////////////////////////////////////////////////
  // Write-back register
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wbck_ena <= 1'b0;
      o_ilegl    <= 1'b0;
    end else begin
      o_wbck_ena <= i_ex_valid & i_ex_rdwen;
      o_ilegl    <= i_ex_valid & i_ex_ilegl;
    end
  end

  always_ff @(posedge clk) begin
    if (i_ex_valid & i_ex_rdwen) begin  // Hold data when nothing writes
      o_wbck_rdidx <= i_ex_rdidx;
      o_wbck_wdat  <= alu_res;
    end
  end

endmodule

`default_nettype wire

// File: hw/exu_decode.sv
// RV32I execution stage, decode
// Decodes OP, OP-IMM, LUI and AUIPC into ALU controls, flags anything
// else illegal and holds the result in the decode register

`timescale 1ns/1ps
`default_nettype none

module exu_decode import exu_pkg::*; (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  logic                 i_valid,
  input  instr_u               i_ir,
  input  logic [XLEN-1:0]      i_pc,
  output logic                 o_dec_valid,
  output logic [ALU_OP_W-1:0]  o_dec_aluop,
  output logic [OP1_SEL_W-1:0] o_dec_op1sel,
  output logic                 o_dec_rs1en,
  output logic                 o_dec_rs2en,
  output logic [RFIDX_W-1:0]   o_dec_rs1idx,
  output logic [RFIDX_W-1:0]   o_dec_rs2idx,
  output logic [RFIDX_W-1:0]   o_dec_rdidx,
  output logic                 o_dec_rdwen,
  output logic [XLEN-1:0]      o_dec_imm,
  output logic [XLEN-1:0]      o_dec_pc,
  output logic                 o_dec_ilegl
);

  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic                 is_op;
  logic                 is_op_imm;
  logic                 is_lui;
  logic                 is_auipc;
  logic                 f7_zero;
  logic                 f7_alt;
  logic                 legal;
  logic [ALU_OP_W-1:0]  aluop;
  logic [OP1_SEL_W-1:0] op1sel;
  logic [XLEN-1:0]      imm;

  assign opcode = i_ir.r_fmt.opcode;
  assign funct3 = i_ir.r_fmt.funct3;
  assign funct7 = i_ir.r_fmt.funct7;  // Also imm[11:5] for shifts

  assign is_op     = (opcode == OPC_OP);
  assign is_op_imm = (opcode == OPC_OP_IMM);
  assign is_lui    = (opcode == OPC_LUI);
  assign is_auipc  = (opcode == OPC_AUIPC);

  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);  // SUB, SRA, SRAI

  ////////////////////////////////////////////////////////////
  // Legality
  // OP allows the alternate funct7 only on ADD/SUB and SRL/SRA,
  // OP-IMM checks the upper immediate bits of the shifts only
  always_comb begin
    legal = is_lui | is_auipc;
    if (is_op) begin
      legal = f7_zero | (f7_alt & ((funct3 == 3'b000) | (funct3 == 3'b101)));
    end else if (is_op_imm) begin
      if (funct3[1:0] == 2'b01) begin
        legal = f7_zero | (f7_alt & funct3[2]);  // No SLLI alternate
      end else begin
        legal = 1'b1;
      end
    end
  end

  always_comb begin
    case (funct3)
      3'b000:  aluop = (is_op & f7_alt) ? ALU_SUB : ALU_ADD;
      3'b001:  aluop = ALU_SLL;
      3'b010:  aluop = ALU_SLT;
      3'b011:  aluop = ALU_SLTU;
      3'b100:  aluop = ALU_XOR;
      3'b101:  aluop = f7_alt ? ALU_SRA : ALU_SRL;
      3'b110:  aluop = ALU_OR;
      default: aluop = ALU_AND;
    endcase
    if (is_lui | is_auipc) begin
      aluop = ALU_ADD;  // op1 + U immediate
    end
  end

  assign op1sel = is_auipc ? OP1_SEL_PC :
                  is_lui   ? OP1_SEL_ZERO : OP1_SEL_REG;

  // U immediate for LUI/AUIPC, sign-extended I immediate otherwise
  assign imm = (is_lui | is_auipc) ? {i_ir.u_fmt.imm20, 12'b0} :
               {{(XLEN-12){i_ir.i_fmt.imm12[11]}}, i_ir.i_fmt.imm12};

  ////////////////////////////////////////////////////////////
  // Decode register
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_dec_valid <= 1'b0;
    end else begin
      o_dec_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_dec_aluop  <= aluop;
      o_dec_op1sel <= op1sel;
      o_dec_rs1en  <= legal & (is_op | is_op_imm);
      o_dec_rs2en  <= legal & is_op;
      o_dec_rs1idx <= i_ir.i_fmt.rs1;
      o_dec_rs2idx <= i_ir.r_fmt.rs2;
      o_dec_rdidx  <= i_ir.u_fmt.rd;
      o_dec_rdwen  <= legal & (i_ir.u_fmt.rd != '0);  // x0 never written
      o_dec_imm    <= imm;
      o_dec_pc     <= i_pc;
      o_dec_ilegl  <= ~legal;
    end
  end

endmodule

`default_nettype wire

// File: hw/exu_disp.sv
// RV32I execution stage, dispatch
// Reads the register file, forwards from the ALU and write-back stages,
// selects both operands and holds them in the execute register

`timescale 1ns/1ps
`default_nettype none

module exu_disp import exu_pkg::*; (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  logic                 i_dec_valid,
  input  logic [ALU_OP_W-1:0]  i_dec_aluop,
  input  logic [OP1_SEL_W-1:0] i_dec_op1sel,
  input  logic                 i_dec_rs1en,
  input  logic                 i_dec_rs2en,
  input  logic [RFIDX_W-1:0]   i_dec_rs1idx,
  input  logic [RFIDX_W-1:0]   i_dec_rs2idx,
  input  logic [RFIDX_W-1:0]   i_dec_rdidx,
  input  logic                 i_dec_rdwen,
  input  logic [XLEN-1:0]      i_dec_imm,
  input  logic [XLEN-1:0]      i_dec_pc,
  input  logic                 i_dec_ilegl,
  output logic [RFIDX_W-1:0]   o_rf_rs1idx,
  output logic [RFIDX_W-1:0]   o_rf_rs2idx,
  input  logic [XLEN-1:0]      i_rf_rs1dat,
  input  logic [XLEN-1:0]      i_rf_rs2dat,
  input  logic                 i_ex_fwd_ena,
  input  logic [RFIDX_W-1:0]   i_ex_fwd_rdidx,
  input  logic [XLEN-1:0]      i_ex_fwd_wdat,
  input  logic                 i_wb_fwd_ena,
  input  logic [RFIDX_W-1:0]   i_wb_fwd_rdidx,
  input  logic [XLEN-1:0]      i_wb_fwd_wdat,
  output logic                 o_ex_valid,
  output logic [ALU_OP_W-1:0]  o_ex_aluop,
  output logic [XLEN-1:0]      o_ex_op1,
  output logic [XLEN-1:0]      o_ex_op2,
  output logic                 o_ex_rdwen,
  output logic [RFIDX_W-1:0]   o_ex_rdidx,
  output logic                 o_ex_ilegl
);

  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;

  assign o_rf_rs1idx = i_dec_rs1idx;
  assign o_rf_rs2idx = i_dec_rs2idx;

  // Newest producer wins: ALU stage, then write-back, then regfile
  function automatic logic [XLEN-1:0] fwd_sel(input logic [RFIDX_W-1:0] idx,
                                              input logic [XLEN-1:0]    rf_dat);
    if (i_ex_fwd_ena && (i_ex_fwd_rdidx == idx)) begin
      return i_ex_fwd_wdat;
    end else if (i_wb_fwd_ena && (i_wb_fwd_rdidx == idx)) begin
      return i_wb_fwd_wdat;
    end
    return rf_dat;
  endfunction

  ////////////////////////////////////////////////////////////
  // Operand select
  always_comb begin
    rs1_val = i_dec_rs1en ? fwd_sel(i_dec_rs1idx, i_rf_rs1dat) : '0;
    rs2_val = i_dec_rs2en ? fwd_sel(i_dec_rs2idx, i_rf_rs2dat) : '0;
    case (i_dec_op1sel)
      OP1_SEL_PC:   op1 = i_dec_pc;
      OP1_SEL_ZERO: op1 = '0;
      default:      op1 = rs1_val;
    endcase
    op2 = i_dec_rs2en ? rs2_val : i_dec_imm;  // Immediate unless OP
  end

  ////////////////////////////////////////////////////////////
  // Execute register
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ex_valid <= 1'b0;
    end else begin
      o_ex_valid <= i_dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_dec_valid) begin
      o_ex_aluop <= i_dec_aluop;
      o_ex_op1   <= op1;
      o_ex_op2   <= op2;
      o_ex_rdwen <= i_dec_rdwen;
      o_ex_rdidx <= i_dec_rdidx;
      o_ex_ilegl <= i_dec_ilegl;
    end
  end

endmodule

`default_nettype wire

// File: hw/exu_pkg.sv
// RV32I execution stage shared definitions
// Widths, major opcodes, ALU op codes, operand-1 selects and the
// instruction-word views used by decode

`default_nettype none

package exu_pkg;

  localparam int unsigned XLEN     = 32;
  localparam int unsigned INSTR_W  = 32;
  localparam int unsigned RFIDX_W  = 5;
  localparam int unsigned RF_NUM   = 32;
  localparam int unsigned ALU_OP_W = 4;

  ////////////////////////////////////////////////////////////
  // ALU op codes
  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  // Operand-1 source
  localparam int unsigned         OP1_SEL_W    = 2;
  localparam logic [OP1_SEL_W-1:0] OP1_SEL_REG  = 2'd0;  // rs1
  localparam logic [OP1_SEL_W-1:0] OP1_SEL_PC   = 2'd1;  // AUIPC
  localparam logic [OP1_SEL_W-1:0] OP1_SEL_ZERO = 2'd2;  // LUI

  ////////////////////////////////////////////////////////////
  // One instruction word, three formats
  typedef union packed {
    struct packed {
      logic [6:0]         funct7;
      logic [RFIDX_W-1:0] rs2;
      logic [RFIDX_W-1:0] rs1;
      logic [2:0]         funct3;
      logic [RFIDX_W-1:0] rd;
      logic [6:0]         opcode;
    } r_fmt;
    struct packed {
      logic [11:0]        imm12;
      logic [RFIDX_W-1:0] rs1;
      logic [2:0]         funct3;
      logic [RFIDX_W-1:0] rd;
      logic [6:0]         opcode;
    } i_fmt;
    struct packed {
      logic [19:0]        imm20;
      logic [RFIDX_W-1:0] rd;
      logic [6:0]         opcode;
    } u_fmt;
  } instr_u;

endpackage

`default_nettype wire

// File: hw/exu_regfile.sv
// Integer register file, x1..x31 in flops and x0 hardwired to zero
// Two combinational read ports, one write port taken at the clock edge

`timescale 1ns/1ps
`default_nettype none

module exu_regfile import exu_pkg::*; (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic [RFIDX_W-1:0] i_rs1idx,
  input  logic [RFIDX_W-1:0] i_rs2idx,
  output logic [XLEN-1:0]    o_rs1dat,
  output logic [XLEN-1:0]    o_rs2dat,
  input  logic               i_wen,
  input  logic [RFIDX_W-1:0] i_wdidx,
  input  logic [XLEN-1:0]    i_wdat
);

  logic [XLEN-1:0] rf_r [1:RF_NUM-1];  // No storage for x0

  ////////////////////////////////////////////////////////////
  // Write port
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < RF_NUM; i++) begin
        rf_r[i] <= '0;
      end
    end else if (i_wen && (i_wdidx != '0)) begin
      rf_r[i_wdidx] <= i_wdat;
    end
  end

  // Read ports
  always_comb begin
    o_rs1dat = '0;
    o_rs2dat = '0;
    if (i_rs1idx != '0) begin
      o_rs1dat = rf_r[i_rs1idx];
    end
    if (i_rs2idx != '0) begin
      o_rs2dat = rf_r[i_rs2idx];
    end
  end

endmodule

`default_nettype wire

// File: hw/exu_top.sv
// RV32I integer execution stage
// Decode, dispatch and ALU in a three-stage pipe with in-order
// write-back to the register file

`timescale 1ns/1ps
`default_nettype none

module exu_top import exu_pkg::*; (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_valid,
  input  logic [INSTR_W-1:0] i_ir,
  input  logic [XLEN-1:0]    i_pc,
  output logic               o_wbck_ena,
  output logic [RFIDX_W-1:0] o_wbck_rdidx,
  output logic [XLEN-1:0]    o_wbck_wdat,
  output logic               o_ilegl,
  output logic               o_exu_active
);

  // Decode register
  logic                 dec_valid;
  logic [ALU_OP_W-1:0]  dec_aluop;
  logic [OP1_SEL_W-1:0] dec_op1sel;
  logic                 dec_rs1en;
  logic                 dec_rs2en;
  logic [RFIDX_W-1:0]   dec_rs1idx;
  logic [RFIDX_W-1:0]   dec_rs2idx;
  logic [RFIDX_W-1:0]   dec_rdidx;
  logic                 dec_rdwen;
  logic [XLEN-1:0]      dec_imm;
  logic [XLEN-1:0]      dec_pc;
  logic                 dec_ilegl;

  // Regfile read ports
  logic [RFIDX_W-1:0]   rf_rs1idx;
  logic [RFIDX_W-1:0]   rf_rs2idx;
  logic [XLEN-1:0]      rf_rs1dat;
  logic [XLEN-1:0]      rf_rs2dat;

  // Execute register and ALU forwarding
  logic                 ex_valid;
  logic [ALU_OP_W-1:0]  ex_aluop;
  logic [XLEN-1:0]      ex_op1;
  logic [XLEN-1:0]      ex_op2;
  logic                 ex_rdwen;
  logic [RFIDX_W-1:0]   ex_rdidx;
  logic                 ex_ilegl;
  logic                 ex_fwd_ena;
  logic [RFIDX_W-1:0]   ex_fwd_rdidx;
  logic [XLEN-1:0]      ex_fwd_wdat;

  ////////////////////////////////////////////////////////////
  exu_decode u_exu_decode (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .i_ir         (i_ir),
    .i_pc         (i_pc),
    .o_dec_valid  (dec_valid),
    .o_dec_aluop  (dec_aluop),
    .o_dec_op1sel (dec_op1sel),
    .o_dec_rs1en  (dec_rs1en),
    .o_dec_rs2en  (dec_rs2en),
    .o_dec_rs1idx (dec_rs1idx),
    .o_dec_rs2idx (dec_rs2idx),
    .o_dec_rdidx  (dec_rdidx),
    .o_dec_rdwen  (dec_rdwen),
    .o_dec_imm    (dec_imm),
    .o_dec_pc     (dec_pc),
    .o_dec_ilegl  (dec_ilegl)
  );

  // Written from the write-back register
  exu_regfile u_exu_regfile (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_rs1idx (rf_rs1idx),
    .i_rs2idx (rf_rs2idx),
    .o_rs1dat (rf_rs1dat),
    .o_rs2dat (rf_rs2dat),
    .i_wen    (o_wbck_ena),
    .i_wdidx  (o_wbck_rdidx),
    .i_wdat   (o_wbck_wdat)
  );

  exu_disp u_exu_disp (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_dec_valid    (dec_valid),
    .i_dec_aluop    (dec_aluop),
    .i_dec_op1sel   (dec_op1sel),
    .i_dec_rs1en    (dec_rs1en),
    .i_dec_rs2en    (dec_rs2en),
    .i_dec_rs1idx   (dec_rs1idx),
    .i_dec_rs2idx   (dec_rs2idx),
    .i_dec_rdidx    (dec_rdidx),
    .i_dec_rdwen    (dec_rdwen),
    .i_dec_imm      (dec_imm),
    .i_dec_pc       (dec_pc),
    .i_dec_ilegl    (dec_ilegl),
    .o_rf_rs1idx    (rf_rs1idx),
    .o_rf_rs2idx    (rf_rs2idx),
    .i_rf_rs1dat    (rf_rs1dat),
    .i_rf_rs2dat    (rf_rs2dat),
    .i_ex_fwd_ena   (ex_fwd_ena),
    .i_ex_fwd_rdidx (ex_fwd_rdidx),
    .i_ex_fwd_wdat  (ex_fwd_wdat),
    .i_wb_fwd_ena   (o_wbck_ena),   // Write-back is the older source
    .i_wb_fwd_rdidx (o_wbck_rdidx),
    .i_wb_fwd_wdat  (o_wbck_wdat),
    .o_ex_valid     (ex_valid),
    .o_ex_aluop     (ex_aluop),
    .o_ex_op1       (ex_op1),
    .o_ex_op2       (ex_op2),
    .o_ex_rdwen     (ex_rdwen),
    .o_ex_rdidx     (ex_rdidx),
    .o_ex_ilegl     (ex_ilegl)
  );

  exu_alu u_exu_alu (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_ex_valid     (ex_valid),
    .i_ex_aluop     (ex_aluop),
    .i_ex_op1       (ex_op1),
    .i_ex_op2       (ex_op2),
    .i_ex_rdwen     (ex_rdwen),
    .i_ex_rdidx     (ex_rdidx),
    .i_ex_ilegl     (ex_ilegl),
    .o_ex_fwd_ena   (ex_fwd_ena),
    .o_ex_fwd_rdidx (ex_fwd_rdidx),
    .o_ex_fwd_wdat  (ex_fwd_wdat),
    .o_wbck_ena     (o_wbck_ena),
    .o_wbck_rdidx   (o_wbck_rdidx),
    .o_wbck_wdat    (o_wbck_wdat),
    .o_ilegl        (o_ilegl)
  );

  // Busy while an instruction enters or sits in a stage
  assign o_exu_active = i_valid | dec_valid | ex_valid;

endmodule

`default_nettype wire

// File: sim.f
hw/exu_pkg.sv
hw/exu_decode.sv
hw/exu_regfile.sv
hw/exu_disp.sv
hw/exu_alu.sv
hw/exu_top.sv
sim/tb_exu.sv

// File: sim/tb_exu.sv
// Testbench for the RV32I execution stage
// LFSR-driven OP, OP-IMM, LUI and AUIPC traffic plus forwarding chains,
// checked cycle by cycle against an architectural register model

`timescale 1ns/1ps
`default_nettype none

module tb_exu import exu_pkg::*; ();

  localparam int unsigned N_RAND    = 300;
  localparam int unsigned N_CHAIN   = 12;   // Per forwarding distance
  localparam int unsigned N_DIR     = 8;
  localparam int unsigned N_INSTR   = N_RAND + 3 * N_CHAIN + N_DIR;
  localparam int unsigned CYC_LIMIT = 2 * N_INSTR + 20;
  localparam int unsigned DRAIN_CYC = 5;
  localparam logic [15:0] LFSR_SEED = 16'd27546;

  logic               clk = 1'b0;
  logic               i_rst_n;
  logic               i_valid;
  instr_u             ir;
  logic [XLEN-1:0]    i_pc;
  logic               o_wbck_ena;
  logic [RFIDX_W-1:0] o_wbck_rdidx;
  logic [XLEN-1:0]    o_wbck_wdat;
  logic               o_ilegl;
  logic               o_exu_active;

  logic [15:0]        lfsr_state;
  logic [XLEN-1:0]    pc_next;
  logic [XLEN-1:0]    rf_m [RF_NUM];  // Architectural registers
  int unsigned        cyc = 0;
  logic               hist1 = 1'b0;   // i_valid one and two cycles back
  logic               hist2 = 1'b0;
  logic               m_wen;
  logic               m_ilegl;
  logic [RFIDX_W-1:0] m_rd;
  logic [XLEN-1:0]    m_dat;

  // Expected results in issue order
  int unsigned        q_due [$];
  logic               q_wen [$];
  logic               q_ilegl [$];
  logic [RFIDX_W-1:0] q_rd [$];
  logic [XLEN-1:0]    q_dat [$];

  always #5 clk = ~clk;

  exu_top dut (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .i_ir         (ir),
    .i_pc         (i_pc),
    .o_wbck_ena   (o_wbck_ena),
    .o_wbck_rdidx (o_wbck_rdidx),
    .o_wbck_wdat  (o_wbck_wdat),
    .o_ilegl      (o_ilegl),
    .o_exu_active (o_exu_active)
  );

  ////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  task automatic stop_run();
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_run(input string what);
    $display("%s", what);
    stop_run();
  endtask

  task automatic check_wdat(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_rdidx(input string name, input logic [RFIDX_W-1:0] got,
                             input logic [RFIDX_W-1:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Random bits, Galois LFSR x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Instruction builders through the format views
  function automatic instr_u mk_r(input logic [6:0] opc, input logic [6:0] f7,
                                  input logic [RFIDX_W-1:0] rs2, input logic [RFIDX_W-1:0] rs1,
                                  input logic [2:0] f3, input logic [RFIDX_W-1:0] rd);
    instr_u w;
    w.r_fmt.funct7 = f7;
    w.r_fmt.rs2    = rs2;
    w.r_fmt.rs1    = rs1;
    w.r_fmt.funct3 = f3;
    w.r_fmt.rd     = rd;
    w.r_fmt.opcode = opc;
    return w;
  endfunction

  function automatic instr_u mk_i(input logic [11:0] imm, input logic [RFIDX_W-1:0] rs1,
                                  input logic [2:0] f3, input logic [RFIDX_W-1:0] rd);
    instr_u w;
    w.i_fmt.imm12  = imm;
    w.i_fmt.rs1    = rs1;
    w.i_fmt.funct3 = f3;
    w.i_fmt.rd     = rd;
    w.i_fmt.opcode = OPC_OP_IMM;
    return w;
  endfunction

  function automatic instr_u mk_u(input logic [6:0] opc, input logic [19:0] imm,
                                  input logic [RFIDX_W-1:0] rd);
    instr_u w;
    w.u_fmt.imm20  = imm;
    w.u_fmt.rd     = rd;
    w.u_fmt.opcode = opc;
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // Architectural model, RV32I semantics
  function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    sa = a;
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      3'b011:  return {{(XLEN-1){1'b0}}, (a < b)};
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) begin
          return sa >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic model_exec(input instr_u w, input logic [XLEN-1:0] pc,
                            output logic wen, output logic [RFIDX_W-1:0] rd,
                            output logic [XLEN-1:0] res, output logic ilegl);
    logic            legal;
    logic            alt;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    legal = 1'b0;
    alt   = 1'b0;
    res   = '0;
    rd    = w.u_fmt.rd;
    a     = rf_m[w.r_fmt.rs1];
    case (w.r_fmt.opcode)
      OPC_OP: begin
        b     = rf_m[w.r_fmt.rs2];
        alt   = (w.r_fmt.funct7 == 7'h20);
        legal = (w.r_fmt.funct7 == 7'h00) ||
                (alt && (w.r_fmt.funct3 inside {3'b000, 3'b101}));
        res   = alu_ref(w.r_fmt.funct3, alt, a, b);
      end
      OPC_OP_IMM: begin
        b = {{(XLEN-12){w.i_fmt.imm12[11]}}, w.i_fmt.imm12};
        if (w.i_fmt.funct3 == 3'b001) begin
          legal = (w.r_fmt.funct7 == 7'h00);
        end else if (w.i_fmt.funct3 == 3'b101) begin
          alt   = (w.r_fmt.funct7 == 7'h20);
          legal = alt || (w.r_fmt.funct7 == 7'h00);
        end else begin
          legal = 1'b1;
        end
        res = alu_ref(w.i_fmt.funct3, alt, a, b);
      end
      OPC_LUI: begin
        legal = 1'b1;
        res   = {w.u_fmt.imm20, 12'h000};
      end
      OPC_AUIPC: begin
        legal = 1'b1;
        res   = pc + {w.u_fmt.imm20, 12'h000};
      end
      default: legal = 1'b0;
    endcase
    ilegl = !legal;
    wen   = legal && (rd != '0);
    if (wen) begin
      rf_m[rd] = res;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus generation
  task automatic gen_random(output instr_u w);
    logic [31:0] kind;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] f3;
    logic [31:0] alt;
    logic [31:0] imm;
    logic [6:0]  f7a;
    draw_bits(3, kind);
    draw_bits(3, rd);
    draw_bits(3, rs1);
    draw_bits(3, rs2);
    draw_bits(3, f3);
    draw_bits(1, alt);
    draw_bits(20, imm);
    f7a = alt[0] ? 7'h20 : 7'h00;
    case (kind[2:0])
      3'd0, 3'd1: begin
        w = mk_r(OPC_OP, (f3[2:0] inside {3'b000, 3'b101}) ? f7a : 7'h00,
                 rs2[4:0], rs1[4:0], f3[2:0], rd[4:0]);
      end
      3'd2, 3'd3, 3'd7: begin
        if (f3[2:0] == 3'b001) begin
          imm[11:5] = 7'h00;
        end else if (f3[2:0] == 3'b101) begin
          imm[11:5] = f7a;
        end
        w = mk_i(imm[11:0], rs1[4:0], f3[2:0], rd[4:0]);
      end
      3'd4:    w = mk_u(OPC_LUI, imm[19:0], rd[4:0]);
      3'd5:    w = mk_u(OPC_AUIPC, imm[19:0], rd[4:0]);
      default: begin  // Illegal encodings
        case (imm[1:0])
          2'd0:    w = mk_r(OPC_OP, 7'h01, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0]);
          2'd1:    w = mk_r(OPC_OP, 7'h20, rs2[4:0], rs1[4:0], 3'b001, rd[4:0]);
          2'd2:    w = mk_r(OPC_OP_IMM, 7'h20, rs2[4:0], rs1[4:0], 3'b001, rd[4:0]);
          default: w = mk_r(7'b0000011, 7'h00, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0]);
        endcase
      end
    endcase
  endtask

  // Producer sits d instructions back; rd never repeats within 3
  task automatic gen_chain(input int i, input int d, output instr_u w);
    logic [31:0]        f3;
    logic [31:0]        alt;
    logic [31:0]        other;
    logic [6:0]         f7;
    logic [RFIDX_W-1:0] rd;
    logic [RFIDX_W-1:0] src;
    draw_bits(3, f3);
    draw_bits(1, alt);
    draw_bits(3, other);
    rd  = RFIDX_W'(1 + (i % 7));
    src = RFIDX_W'(1 + ((i + 7 - d) % 7));
    f7  = (alt[0] && (f3[2:0] inside {3'b000, 3'b101})) ? 7'h20 : 7'h00;
    if (i % 2 == 0) begin
      w = mk_r(OPC_OP, f7, src, other[4:0], f3[2:0], rd);
    end else begin
      w = mk_r(OPC_OP, f7, other[4:0], src, f3[2:0], rd);
    end
  endtask

  task automatic issue(input instr_u w);
    @(posedge clk);
    i_valid <= 1'b1;
    ir      <= w;
    i_pc    <= pc_next;
    pc_next = pc_next + 32'd4;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    i_valid <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Output checks, once per cycle where outputs are stable
  task automatic check_cycle();
    check_flag("o_exu_active", o_exu_active, i_valid | hist1 | hist2);
    if ((q_due.size() != 0) && (q_due[0] == cyc)) begin
      check_flag("o_wbck_ena", o_wbck_ena, q_wen[0]);
      check_flag("o_ilegl", o_ilegl, q_ilegl[0]);
      if (q_wen[0]) begin
        check_rdidx("o_wbck_rdidx", o_wbck_rdidx, q_rd[0]);
        check_wdat("o_wbck_wdat", o_wbck_wdat, q_dat[0]);
      end
      q_due.delete(0);
      q_wen.delete(0);
      q_ilegl.delete(0);
      q_rd.delete(0);
      q_dat.delete(0);
    end else begin
      check_flag("o_wbck_ena", o_wbck_ena, 1'b0);  // Also rd 0 and reset
      check_flag("o_ilegl", o_ilegl, 1'b0);
    end
    hist2 = hist1;
    hist1 = i_valid;
    if (i_valid) begin
      model_exec(ir, i_pc, m_wen, m_rd, m_dat, m_ilegl);
      if (m_wen || m_ilegl) begin
        q_due.push_back(cyc + 3);  // Fixed 3-cycle latency
        q_wen.push_back(m_wen);
        q_ilegl.push_back(m_ilegl);
        q_rd.push_back(m_rd);
        q_dat.push_back(m_dat);
      end
    end
  endtask

  always @(negedge clk) begin
    cyc = cyc + 1;
    if (cyc > CYC_LIMIT) begin
      fail_run($sformatf("Timeout, run did not finish within %0d cycles", CYC_LIMIT));
    end else begin
      check_cycle();
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  initial begin
    logic [31:0] gap;
    instr_u      w;
    lfsr_state = LFSR_SEED;
    pc_next    = 32'h8000_0000;
    i_rst_n    = 1'b0;
    i_valid    = 1'b0;
    ir         = '0;
    i_pc       = '0;
    for (int r = 0; r < RF_NUM; r++) begin
      rf_m[r] = '0;
    end
    repeat (3) @(posedge clk);
    i_rst_n <= 1'b1;

    // Random mix, about one idle cycle in four
    for (int n = 0; n < N_RAND; n++) begin
      draw_bits(2, gap);
      if (gap[1:0] == 2'b00) begin
        idle_cycle();
      end
      gen_random(w);
      issue(w);
    end

    // Back-to-back dependent chains, ALU, write-back and regfile sources
    for (int d = 1; d <= 3; d++) begin
      for (int n = 0; n < N_CHAIN; n++) begin
        gen_chain(n, d, w);
        issue(w);
      end
    end

    // Illegal encodings and rd 0, then read the targets back
    issue(mk_r(OPC_OP, 7'h01, 5'd2, 5'd1, 3'b000, 5'd3));
    issue(mk_r(OPC_OP_IMM, 7'h20, 5'd4, 5'd1, 3'b001, 5'd2));
    issue(mk_r(7'b0000011, 7'h00, 5'd0, 5'd1, 3'b010, 5'd5));
    issue(mk_i(12'h7ff, 5'd1, 3'b000, 5'd0));
    issue(mk_u(OPC_LUI, 20'hABCDE, 5'd0));
    issue(mk_r(OPC_OP, 7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
    issue(mk_r(OPC_OP, 7'h00, 5'd2, 5'd3, 3'b000, 5'd6));
    issue(mk_r(OPC_OP, 7'h00, 5'd0, 5'd5, 3'b100, 5'd7));
    idle_cycle();

    repeat (DRAIN_CYC) @(posedge clk);
    if (q_due.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      fail_run($sformatf("%0d expected results never appeared", q_due.size()));
    end
  end

endmodule

`default_nettype wire
